//--- hdl/dccm_pkg.sv
package dccm_pkg;

   localparam int DATA_W  = 32;            // bits per bank word
   localparam int BYTES_W = DATA_W / 8;    // bytes per bank word
   localparam int INDEX_W = 12;            // word index field of an address
   localparam int ADDR_W  = INDEX_W + 3;   // index + bank + byte offset

   typedef logic [DATA_W-1:0]    word_t;
   typedef logic [2*DATA_W-1:0]  dword_t;  // second word high, first word low
   typedef logic [2*BYTES_W-1:0] byteen_t;

   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } size_e;

   // byte address, seen flat for arithmetic or split for bank steering
   typedef union packed {
      logic [ADDR_W-1:0] flat;
      struct packed {
         logic [INDEX_W-1:0] index;
         logic               bank;         // selects lo/hi bank
         logic [1:0]         offset;       // byte within the word
      } f;
   } addr_t;

   typedef struct packed {
      logic  valid;
      size_e size;
      addr_t addr;
   } ld_req_t;

   typedef struct packed {
      logic  valid;
      word_t data;                         // right justified
   } ld_rsp_t;

   // store buffer forwarding for the load in M
   typedef struct packed {
      byteen_t byteen;
      dword_t  data;
   } fwd_t;

   typedef struct packed {
      logic  valid;
      addr_t addr;                         // word aligned
      word_t data;
   } stbuf_req_t;

   typedef struct packed {
      logic               en;
      logic [INDEX_W-1:0] index;
   } bank_rd_t;

   typedef struct packed {
      logic               en;
      logic [INDEX_W-1:0] index;
      word_t              data;
   } bank_wr_t;

   typedef logic [1:0] bank_use_t;         // bit 0 lo bank, bit 1 hi bank

endpackage

//--- hdl/dccm_bank.sv
`timescale 1ns/100ps

module dccm_bank #(
   parameter int BANK_INDEX_W = 8
) (
   input  logic               clk,
   input  dccm_pkg::bank_rd_t rd,
   input  dccm_pkg::bank_wr_t wr,
   output dccm_pkg::word_t    rd_data
);

   localparam int DEPTH = 2 ** BANK_INDEX_W;

   dccm_pkg::word_t mem [DEPTH];

   // single port, a write takes the cycle over a read
   always_ff @(posedge clk) begin
      if (wr.en) begin
         mem[wr.index[BANK_INDEX_W-1:0]] <= wr.data;
      end else if (rd.en) begin
         rd_data <= mem[rd.index[BANK_INDEX_W-1:0]];   // one cycle latency
      end
   end

   // the arbiter keeps a drain off a bank the load reads
   a_no_rd_wr_clash: assert property (@(posedge clk) !(rd.en && wr.en))
      else $error("bank read and write in the same cycle");

   // the port only decodes the low index bits
   a_index_in_range: assert property (@(posedge clk)
      (rd.en -> ((rd.index >> BANK_INDEX_W) == '0)) &&
      (wr.en -> ((wr.index >> BANK_INDEX_W) == '0)))
      else $error("bank index beyond bank depth");

endmodule

//--- hdl/dccm_port_arb.sv
`timescale 1ns/100ps

module dccm_port_arb (
   input  logic                 clk,
   input  logic                 arst_n,
   input  dccm_pkg::stbuf_req_t stbuf_req,
   input  dccm_pkg::bank_use_t  bank_use,
   output logic                 stbuf_commit,
   output dccm_pkg::bank_wr_t   bank_wr_lo,
   output dccm_pkg::bank_wr_t   bank_wr_hi
);

   logic sb_bank;      // bank of the pending entry
   logic sb_blocked;   // load in D reads that bank

   assign sb_bank    = stbuf_req.addr.f.bank;
   assign sb_blocked = bank_use[sb_bank];

   // drain whenever the load leaves the entry's bank free
   assign stbuf_commit = stbuf_req.valid & ~sb_blocked;

   // both ports see the entry, only its own bank gets the enable
   always_comb begin
      bank_wr_lo.en    = stbuf_commit & ~sb_bank;
      bank_wr_lo.index = stbuf_req.addr.f.index;
      bank_wr_lo.data  = stbuf_req.data;

      bank_wr_hi.en    = stbuf_commit & sb_bank;
      bank_wr_hi.index = stbuf_req.addr.f.index;
      bank_wr_hi.data  = stbuf_req.data;
   end

   // a refused entry must be offered again unchanged
   a_entry_held: assert property (@(posedge clk) disable iff (!arst_n)
      (stbuf_req.valid && !stbuf_commit) |=>
         (stbuf_req.valid && $stable(stbuf_req.addr) && $stable(stbuf_req.data)))
      else $error("store buffer entry dropped before commit");

endmodule

//--- hdl/dccm_load_pipe.sv
`timescale 1ns/100ps

module dccm_load_pipe (
   input  logic                clk,
   input  logic                arst_n,
   input  dccm_pkg::ld_req_t   ld_req,
   input  dccm_pkg::fwd_t      fwd,
   output dccm_pkg::bank_rd_t  bank_rd_lo,
   output dccm_pkg::bank_rd_t  bank_rd_hi,
   output dccm_pkg::bank_use_t bank_use,
   input  dccm_pkg::word_t     rd_data_lo,
   input  dccm_pkg::word_t     rd_data_hi,
   output dccm_pkg::ld_rsp_t   ld_rsp
);

   dccm_pkg::addr_t  end_addr;   // address of the last byte
   logic [1:0]       size_m1;    // access bytes minus one
   logic             cross_d;    // access spills into the next word
   logic             m_valid;
   logic             m_bank;     // start bank of the load in M
   logic             m_cross;
   logic [1:0]       m_offset;
   dccm_pkg::word_t  first_m;
   dccm_pkg::word_t  second_m;
   logic             r_valid;
   logic [1:0]       r_offset;
   dccm_pkg::dword_t r_pair;
   dccm_pkg::fwd_t   r_fwd;
   dccm_pkg::dword_t merged;
   dccm_pkg::dword_t shifted;

   always_comb begin
      case (ld_req.size)
         dccm_pkg::SZ_HALF: size_m1 = 2'd1;
         dccm_pkg::SZ_WORD: size_m1 = 2'd3;
         default:           size_m1 = 2'd0;
      endcase
   end

   assign end_addr.flat = ld_req.addr.flat + dccm_pkg::ADDR_W'(size_m1);
   assign cross_d       = ld_req.addr.f.bank ^ end_addr.f.bank;

   // D stage, each bank serves whichever word lives in it
   assign bank_use[0] = ld_req.valid & (~ld_req.addr.f.bank | ~end_addr.f.bank);
   assign bank_use[1] = ld_req.valid & (ld_req.addr.f.bank | end_addr.f.bank);

   assign bank_rd_lo.en    = bank_use[0];
   assign bank_rd_lo.index = ld_req.addr.f.bank ? end_addr.f.index : ld_req.addr.f.index;
   assign bank_rd_hi.en    = bank_use[1];
   assign bank_rd_hi.index = ld_req.addr.f.bank ? ld_req.addr.f.index : end_addr.f.index;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         m_valid <= 1'b0;
         r_valid <= 1'b0;
      end else begin
         m_valid <= ld_req.valid;
         r_valid <= m_valid;
      end
   end

   // M stage, put bank data back in address order
   assign first_m  = m_bank ? rd_data_hi : rd_data_lo;
   assign second_m = m_cross ? (m_bank ? rd_data_lo : rd_data_hi) : first_m;

   always_ff @(posedge clk) begin
      m_bank   <= ld_req.addr.f.bank;
      m_cross  <= cross_d;
      m_offset <= ld_req.addr.f.offset;
      r_offset <= m_offset;
      r_pair   <= {second_m, first_m};
      r_fwd    <= fwd;   // forwarding belongs to the load in M
   end

   // R stage, forwarded bytes win over bank bytes
   always_comb begin
      for (int i = 0; i < 2 * dccm_pkg::BYTES_W; i++) begin
         merged[8*i +: 8] = r_fwd.byteen[i] ? r_fwd.data[8*i +: 8] : r_pair[8*i +: 8];
      end
   end

   assign shifted     = merged >> {r_offset, 3'b000};
   assign ld_rsp.valid = r_valid;
   assign ld_rsp.data  = shifted[dccm_pkg::DATA_W-1:0];   // upper bytes left as read

   // size 3 has no meaning and would read as a byte
   a_size_legal: assert property (@(posedge clk) disable iff (!arst_n)
      ld_req.valid |-> (ld_req.size != 2'd3))
      else $error("load request with an undefined size");

endmodule

//--- hdl/dccm_ctl_top.sv
`timescale 1ns/100ps

module dccm_ctl_top #(
   parameter int BANK_INDEX_W = 8
) (
   input  logic                 clk,
   input  logic                 arst_n,
   input  dccm_pkg::ld_req_t    ld_req,
   input  dccm_pkg::fwd_t       fwd,
   input  dccm_pkg::stbuf_req_t stbuf_req,
   output logic                 stbuf_commit,
   output dccm_pkg::ld_rsp_t    ld_rsp
);

   dccm_pkg::bank_rd_t  bank_rd_lo;
   dccm_pkg::bank_rd_t  bank_rd_hi;
   dccm_pkg::bank_wr_t  bank_wr_lo;
   dccm_pkg::bank_wr_t  bank_wr_hi;
   dccm_pkg::bank_use_t bank_use;     // banks the load in D reads
   dccm_pkg::word_t     rd_data_lo;
   dccm_pkg::word_t     rd_data_hi;

   dccm_load_pipe i_load_pipe (
      .clk        (clk),
      .arst_n     (arst_n),
      .ld_req     (ld_req),
      .fwd        (fwd),
      .bank_rd_lo (bank_rd_lo),
      .bank_rd_hi (bank_rd_hi),
      .bank_use   (bank_use),
      .rd_data_lo (rd_data_lo),
      .rd_data_hi (rd_data_hi),
      .ld_rsp     (ld_rsp)
   );

   dccm_port_arb i_port_arb (
      .clk          (clk),
      .arst_n       (arst_n),
      .stbuf_req    (stbuf_req),
      .bank_use     (bank_use),
      .stbuf_commit (stbuf_commit),
      .bank_wr_lo   (bank_wr_lo),
      .bank_wr_hi   (bank_wr_hi)
   );

   // address bit 2 clear
   dccm_bank #(.BANK_INDEX_W(BANK_INDEX_W)) i_bank_lo (
      .clk     (clk),
      .rd      (bank_rd_lo),
      .wr      (bank_wr_lo),
      .rd_data (rd_data_lo)
   );

   // address bit 2 set
   dccm_bank #(.BANK_INDEX_W(BANK_INDEX_W)) i_bank_hi (
      .clk     (clk),
      .rd      (bank_rd_hi),
      .wr      (bank_wr_hi),
      .rd_data (rd_data_hi)
   );

endmodule

//--- tests/tb_dccm_ctl.sv
`timescale 1ns/100ps

module tb_dccm_ctl;

   localparam int FILL_WORDS = 128;                 // words preloaded through the store buffer
   localparam int LD_TOP     = FILL_WORDS * 4 - 4;  // last start byte, keeps the pair in range

   logic                 clk;
   logic                 arst_n;
   dccm_pkg::ld_req_t    ld_req;
   dccm_pkg::fwd_t       fwd;
   dccm_pkg::stbuf_req_t stbuf_req;
   logic                 stbuf_commit;
   dccm_pkg::ld_rsp_t    ld_rsp;

   dccm_pkg::word_t      model [2 * 256];  // word address = {index, bank}
   dccm_pkg::word_t      exp_q [$];
   int                   due_q [$];
   dccm_pkg::ld_req_t    m_load;           // load now in M
   dccm_pkg::ld_req_t    d_load;           // load now in D
   dccm_pkg::ld_req_t    idle;
   logic                 fwd_on;
   int                   cyc = 0;
   string                test_name = "reset";

   dccm_ctl_top i_dut (
      .clk          (clk),
      .arst_n       (arst_n),
      .ld_req       (ld_req),
      .fwd          (fwd),
      .stbuf_req    (stbuf_req),
      .stbuf_commit (stbuf_commit),
      .ld_rsp       (ld_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_word(input string name, input dccm_pkg::word_t exp,
                             input dccm_pkg::word_t act);
      if (act !== exp) begin
         stop_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         stop_run($sformatf("FAIL %s: expected %b, actual %b", name, exp, act));
      end
   endtask

   function automatic int size_bytes(input dccm_pkg::size_e s);
      case (s)
         dccm_pkg::SZ_HALF: return 2;
         dccm_pkg::SZ_WORD: return 4;
         default:           return 1;
      endcase
   endfunction

   // words at first and last byte, forwarded bytes on top, shifted by the offset
   function automatic dccm_pkg::word_t ref_load(input dccm_pkg::ld_req_t req,
                                                input dccm_pkg::fwd_t f);
      int               start;
      int               last;
      dccm_pkg::dword_t pair;
      start = int'(req.addr.flat);
      last  = start + size_bytes(req.size) - 1;
      pair  = {model[last / 4], model[start / 4]};
      for (int i = 0; i < 8; i++) begin
         if (f.byteen[i]) pair[8*i +: 8] = f.data[8*i +: 8];
      end
      pair = pair >> (8 * (start % 4));
      return pair[31:0];   // upper bytes stay unmasked
   endfunction

   // entry drains unless its bank holds the first or last byte of the load
   function automatic logic commit_rule(input dccm_pkg::ld_req_t ld,
                                        input dccm_pkg::stbuf_req_t sb);
      int   start;
      int   last;
      logic sb_bank;
      start   = int'(ld.addr.flat);
      last    = start + size_bytes(ld.size) - 1;
      sb_bank = sb.addr.flat[2];
      if (!sb.valid) return 1'b0;
      if (!ld.valid) return 1'b1;
      return (sb_bank != start[2]) && (sb_bank != last[2]);
   endfunction

   function automatic dccm_pkg::ld_req_t rand_load();
      dccm_pkg::ld_req_t r;
      r.valid     = 1'b1;
      r.size      = dccm_pkg::size_e'($urandom_range(0, 2));
      r.addr.flat = dccm_pkg::ADDR_W'($urandom_range(0, LD_TOP));
      return r;
   endfunction

   function automatic dccm_pkg::stbuf_req_t rand_entry();
      dccm_pkg::stbuf_req_t s;
      s.valid     = 1'b1;
      s.addr.flat = dccm_pkg::ADDR_W'($urandom_range(0, FILL_WORDS - 1) * 4);
      s.data      = $urandom();
      return s;
   endfunction

   // one falling edge: forwarding and expected value for M, new load into D
   task automatic next_cycle(input dccm_pkg::ld_req_t req);
      dccm_pkg::fwd_t f;
      @(negedge clk);
      f = '0;
      if (m_load.valid) begin
         if (fwd_on) begin
            f.byteen = dccm_pkg::byteen_t'($urandom_range(0, 255));
            f.data   = {$urandom(), $urandom()};
         end
         exp_q.push_back(ref_load(m_load, f));
         due_q.push_back(cyc + 2);
      end
      fwd    = f;
      ld_req = req;
      m_load = req;
      d_load = req;
   endtask

   task automatic drain_pipe();
      for (int i = 0; i < 10 && (exp_q.size() != 0 || m_load.valid); i++) begin
         next_cycle(idle);
      end
      if (exp_q.size() != 0 || m_load.valid) stop_run("load responses did not drain in time");
   endtask

   // bank model follows every committed entry
   always @(posedge clk) begin
      if (arst_n && stbuf_req.valid && stbuf_commit) begin
         model[int'(stbuf_req.addr.flat) / 4] = stbuf_req.data;
      end
   end

   always @(posedge clk) begin : compare_rsp
      dccm_pkg::word_t exp_w;
      int              due;
      cyc = cyc + 1;
      if (arst_n) begin
         if (ld_rsp.valid) begin
            if (exp_q.size() == 0) begin
               stop_run("load response with no load outstanding");
            end else begin
               exp_w = exp_q.pop_front();
               due   = due_q.pop_front();
               if (due != cyc) stop_run("load response arrived in the wrong cycle");
               else check_word(test_name, exp_w, ld_rsp.data);
            end
         end else if (exp_q.size() != 0 && due_q[0] <= cyc) begin
            stop_run("load response missing two cycles after issue");
         end
      end
   end

   initial begin : stimulus
      logic exp_c;
      logic sb_done;
      int   sb_wait;
      void'($urandom(32'hb6163a2f));
      arst_n    = 1'b0;
      ld_req    = '0;
      fwd       = '0;
      stbuf_req = '0;
      m_load    = '0;
      d_load    = '0;
      idle      = '0;
      fwd_on    = 1'b0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      test_name = "idle after reset";
      repeat (6) begin
         next_cycle(idle);
         @(posedge clk);
         check_bit("idle rsp valid", 1'b0, ld_rsp.valid);
         check_bit("idle commit", 1'b0, stbuf_commit);
      end

      test_name = "fill and aligned words";
      for (int w = 0; w < FILL_WORDS; w++) begin
         next_cycle(idle);
         stbuf_req.valid     = 1'b1;
         stbuf_req.addr.flat = dccm_pkg::ADDR_W'(w * 4);
         stbuf_req.data      = $urandom();
         @(posedge clk);
         check_bit("fill commit", 1'b1, stbuf_commit);   // no load, lane is free
      end
      next_cycle(idle);
      stbuf_req = '0;
      for (int w = 0; w < FILL_WORDS; w++) begin
         next_cycle('{valid: 1'b1, size: dccm_pkg::SZ_WORD,
                      addr: dccm_pkg::ADDR_W'(w * 4)});
      end
      drain_pipe();

      test_name = "sizes and offsets";
      for (int sz = 0; sz < 3; sz++) begin
         for (int a = 0; a < 40; a++) begin
            next_cycle('{valid: 1'b1, size: dccm_pkg::size_e'(sz),
                         addr: dccm_pkg::ADDR_W'(a)});
         end
      end
      drain_pipe();

      test_name = "forwarding merge";
      fwd_on = 1'b1;
      repeat (100) next_cycle(rand_load());
      drain_pipe();

      test_name = "commit against load";
      fwd_on = 1'b0;
      repeat (40) begin
         next_cycle(rand_load());
         stbuf_req = rand_entry();
         @(posedge clk);
         exp_c = commit_rule(d_load, stbuf_req);
         check_bit("collision commit", exp_c, stbuf_commit);
         if (!exp_c) begin
            next_cycle(idle);                  // entry held, lane now free
            @(posedge clk);
            check_bit("deferred commit", 1'b1, stbuf_commit);
         end
         next_cycle(idle);
         stbuf_req = '0;
      end
      drain_pipe();

      test_name = "random mix";
      fwd_on  = 1'b1;
      sb_done = 1'b0;
      sb_wait = 0;
      for (int i = 0; i < 300; i++) begin
         next_cycle(($urandom_range(0, 2) != 0) ? rand_load() : idle);
         if (sb_done) begin
            stbuf_req = '0;
            sb_done   = 1'b0;
         end
         if (!stbuf_req.valid && $urandom_range(0, 1) == 1) stbuf_req = rand_entry();
         @(posedge clk);
         check_bit("mix commit", commit_rule(d_load, stbuf_req), stbuf_commit);
         if (stbuf_req.valid && stbuf_commit) begin
            sb_done = 1'b1;
            sb_wait = 0;
         end else if (stbuf_req.valid) begin
            sb_wait++;
         end
         if (sb_wait > 20) stop_run("store buffer entry not committed within 20 cycles");
      end
      next_cycle(idle);
      if (sb_done) stbuf_req = '0;   // a pending entry drains in this idle cycle
      next_cycle(idle);
      stbuf_req = '0;
      drain_pipe();

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

//--- project.f
hdl/dccm_pkg.sv
hdl/dccm_bank.sv
hdl/dccm_port_arb.sv
hdl/dccm_load_pipe.sv
hdl/dccm_ctl_top.sv
tests/tb_dccm_ctl.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dccm_ctl
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TESTBENCH PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
